// File: common/npc_pkg.sv
/* core widths, opcodes, decode enums and the
   structs for data memory requests and retired instructions */
package npc_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [2:0] {
        TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J, TYPE_N
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        inst_type_t            inst_type;
        alu_op_t               alu_op;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      wmask;  // one bit per byte lane
        logic            write;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  we;
    } commit_t;

endpackage

// File: exu/alu.sv
/* RV32I integer ALU */
`timescale 1ns/10ps

module alu import npc_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_t         op,
    output logic [XLEN-1:0] result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// File: exu/exu.sv
/* execute unit, operand select and branch / jump resolution */
`timescale 1ns/10ps

module exu import npc_pkg::*; (
    input  decode_t         dec,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] alu_result,
    output logic            jump_en,
    output logic [XLEN-1:0] jump_target
);
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic            branch_taken;

    always_comb begin
        case (dec.inst_type)
            TYPE_U:         alu_a = (dec.opcode == OP_LUI) ? '0 : pc;
            TYPE_J, TYPE_B: alu_a = pc;
            default:        alu_a = rs1_data;
        endcase
        alu_b = (dec.inst_type == TYPE_R) ? rs2_data : dec.imm;
    end

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (dec.alu_op),
        .result(alu_result)
    );

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en = (dec.opcode == OP_JAL) || (dec.opcode == OP_JALR)
                  || (dec.opcode == OP_BRANCH && branch_taken);
        if (dec.opcode == OP_JALR)
            jump_target = {alu_result[XLEN-1:1], 1'b0};
        else
            jump_target = alu_result;
    end

endmodule

// File: rtl/ifu.sv
/* instruction fetch unit with pc and fetch FSM */
`timescale 1ns/10ps

module ifu import npc_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            imem_req_valid,
    input  logic            imem_req_ready,
    output logic [XLEN-1:0] imem_addr,
    input  logic            imem_resp_valid,
    input  logic [XLEN-1:0] imem_rdata,
    output logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] pc,
    output logic            exec_valid,
    input  logic            done,
    input  logic            jump_en,
    input  logic [XLEN-1:0] jump_target
);
    typedef enum logic [1:0] {S_REQ, S_WAIT, S_EXEC} state_t;
    state_t state, next_state;

    always_comb begin
        next_state = state;
        case (state)
            S_REQ:   if (imem_req_valid && imem_req_ready) next_state = S_WAIT;
            S_WAIT:  if (imem_resp_valid) next_state = S_EXEC;
            S_EXEC:  if (done) next_state = S_REQ;
            default: next_state = S_REQ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= S_REQ;
            pc             <= RESET_PC;
            imem_req_valid <= 1'b0;  // first request one cycle out of reset
        end else begin
            state          <= next_state;
            imem_req_valid <= (next_state == S_REQ);
            if (state == S_EXEC && done)
                pc <= jump_en ? jump_target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && imem_resp_valid)
            inst <= imem_rdata;
    end

    assign imem_addr  = pc;
    assign exec_valid = (state == S_EXEC);

endmodule

// File: rtl/idu.sv
/* instruction decoder, fields, format, immediates and ALU op */
`timescale 1ns/10ps

module idu import npc_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output decode_t         dec
);
    logic [6:0] opcode;
    logic       funct7_5;

    assign opcode   = inst[6:0];
    assign funct7_5 = inst[30];  // sub / sra select

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (opcode)
            OP_REG:                   dec.inst_type = TYPE_R;
            OP_IMM, OP_LOAD, OP_JALR: dec.inst_type = TYPE_I;
            OP_STORE:                 dec.inst_type = TYPE_S;
            OP_BRANCH:                dec.inst_type = TYPE_B;
            OP_LUI, OP_AUIPC:         dec.inst_type = TYPE_U;
            OP_JAL:                   dec.inst_type = TYPE_J;
            default:                  dec.inst_type = TYPE_N;
        endcase

        case (dec.inst_type)
            TYPE_I:  dec.imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B: begin
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                           inst[11:8], 1'b0};
            end
            TYPE_U:  dec.imm = {inst[31:12], 12'h000};
            TYPE_J: begin
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                           inst[30:21], 1'b0};
            end
            default: dec.imm = '0;
        endcase

        dec.alu_op = ALU_ADD;  // address and pc arithmetic
        if (opcode == OP_IMM || opcode == OP_REG) begin
            case (inst[14:12])
                3'b000: dec.alu_op = (opcode == OP_REG && funct7_5) ? ALU_SUB : ALU_ADD;
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// File: rtl/lsu.sv
/* load/store unit, data memory exchange, byte lanes and load extension */
`timescale 1ns/10ps

module lsu import npc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  decode_t         dec,
    input  logic            exec_valid,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_data,
    output logic            dmem_req_valid,
    input  logic            dmem_req_ready,
    output mem_req_t        dmem_req,
    input  logic            dmem_resp_valid,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic [XLEN-1:0] load_data,
    output logic            done
);
    typedef enum logic {L_ISSUE, L_WAIT} state_t;
    state_t state;

    logic       is_mem;
    logic [4:0] lane_shift;
    logic [XLEN-1:0] rdata_shifted;

    assign is_mem     = (dec.opcode == OP_LOAD) || (dec.opcode == OP_STORE);
    assign lane_shift = {addr[1:0], 3'b000};

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= L_ISSUE;
        else if (state == L_ISSUE && dmem_req_valid && dmem_req_ready)
            state <= L_WAIT;
        else if (state == L_WAIT && dmem_resp_valid)
            state <= L_ISSUE;
    end

    assign dmem_req_valid = exec_valid && is_mem && (state == L_ISSUE);
    assign done = exec_valid && (!is_mem || (state == L_WAIT && dmem_resp_valid));

    always_comb begin
        dmem_req.addr  = addr;
        dmem_req.wdata = store_data << lane_shift;
        dmem_req.write = (dec.opcode == OP_STORE);
        case (dec.funct3[1:0])
            2'b00:   dmem_req.wmask = 4'b0001 << addr[1:0];  // sb
            2'b01:   dmem_req.wmask = 4'b0011 << addr[1:0];  // sh
            default: dmem_req.wmask = 4'b1111;
        endcase
        if (!dmem_req.write)
            dmem_req.wmask = 4'b0000;
    end

    assign rdata_shifted = dmem_rdata >> lane_shift;

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            3'b001:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            3'b100:  load_data = {24'h0, rdata_shifted[7:0]};   // lbu
            3'b101:  load_data = {16'h0, rdata_shifted[15:0]};  // lhu
            default: load_data = rdata_shifted;
        endcase
    end

endmodule

// File: rtl/gpr.sv
/* writeback select, 32-entry register file and commit record */
`timescale 1ns/10ps

module gpr import npc_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  decode_t         dec,
    input  logic [XLEN-1:0] pc,
    input  logic            done,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    output logic            commit_valid,
    output commit_t         commit
);
    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] wdata;
    logic            we;

    always_comb begin
        case (dec.opcode)
            OP_JAL, OP_JALR: wdata = pc + 32'd4;  // link address
            OP_LOAD:         wdata = load_data;
            default:         wdata = alu_result;
        endcase
        case (dec.opcode)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG: we = 1'b1;
            default: we = 1'b0;
        endcase
        if (dec.rd == '0)
            we = 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (done && we)
                regs[dec.rd] <= wdata;
            commit_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done)
            commit <= '{pc: pc, rd: dec.rd, wdata: wdata, we: we};
    end

    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// File: rtl/npc_core.sv
/* multi-cycle RV32I core top level */
`timescale 1ns/10ps

module npc_core import npc_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            imem_req_valid,
    input  logic            imem_req_ready,
    output logic [XLEN-1:0] imem_addr,
    input  logic            imem_resp_valid,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            dmem_req_valid,
    input  logic            dmem_req_ready,
    output mem_req_t        dmem_req,
    input  logic            dmem_resp_valid,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic            commit_valid,
    output commit_t         commit
);
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic            exec_valid;
    logic            done;
    logic            jump_en;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] load_data;
    decode_t         dec;

    ifu #(.RESET_PC(RESET_PC)) u_ifu (
        .clk(clk), .reset(reset),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr), .imem_resp_valid(imem_resp_valid),
        .imem_rdata(imem_rdata), .inst(inst), .pc(pc), .exec_valid(exec_valid),
        .done(done), .jump_en(jump_en), .jump_target(jump_target)
    );

    idu u_idu (.inst(inst), .dec(dec));

    exu u_exu (
        .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc),
        .alu_result(alu_result), .jump_en(jump_en), .jump_target(jump_target)
    );

    lsu u_lsu (
        .clk(clk), .reset(reset), .dec(dec), .exec_valid(exec_valid),
        .addr(alu_result), .store_data(rs2_data),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_req(dmem_req), .dmem_resp_valid(dmem_resp_valid),
        .dmem_rdata(dmem_rdata), .load_data(load_data), .done(done)
    );

    gpr u_gpr (
        .clk(clk), .reset(reset), .dec(dec), .pc(pc), .done(done),
        .alu_result(alu_result), .load_data(load_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .commit_valid(commit_valid), .commit(commit)
    );

endmodule

// File: tests/tb_clock.sv
/* testbench clock and power-on reset */
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tests/tb_top.sv
/* core testbench with memory models, program builder,
   reference model and commit checks */
`timescale 1ns/10ps

module tb_top import npc_pkg::*; ();
    localparam logic [31:0] RESET_PC     = 32'h8000_0000;
    localparam logic [31:0] SEED         = 32'h1555_16c4;
    localparam int          RESET_CYCLES = 8;
    localparam int          IMEM_WORDS   = 1024;
    localparam int          DMEM_WORDS   = 256;
    localparam int          NUM_TESTS    = 5;

    logic            clk;
    logic            reset;
    logic            imem_req_valid;
    logic            imem_req_ready = 1'b0;
    logic [XLEN-1:0] imem_addr;
    logic            imem_resp_valid = 1'b0;
    logic [XLEN-1:0] imem_rdata = '0;
    logic            dmem_req_valid;
    logic            dmem_req_ready = 1'b0;
    mem_req_t        dmem_req;
    logic            dmem_resp_valid = 1'b0;
    logic [XLEN-1:0] dmem_rdata = '0;
    logic            commit_valid;
    commit_t         commit;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] ref_dmem [DMEM_WORDS];
    logic [31:0] rregs [32];
    logic [31:0] ref_pc;
    commit_t     exp_q[$];
    int          exp_test[$];
    mem_req_t    store_q[$];
    int          store_test[$];
    int          cur_test;
    int          test_len[NUM_TESTS] = '{default: 0};
    int          seen[NUM_TESTS] = '{default: 0};
    int          errors[NUM_TESTS] = '{default: 0};
    string       names[NUM_TESTS] = '{"reset", "alu", "branch/jump", "load/store", "stall stream"};
    int          limit = 0;
    int          cycles = 0;
    bit          all_done = 1'b0;
    bit          first_req_seen = 1'b0;
    bit          inst_busy = 1'b0;
    bit          data_busy = 1'b0;

    tb_clock #(.PERIOD(8.0), .RESET_CYCLES(RESET_CYCLES)) clk_gen (.clk(clk), .reset(reset));

    npc_core #(.RESET_PC(RESET_PC)) dut_i (
        .clk(clk), .reset(reset),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr), .imem_resp_valid(imem_resp_valid), .imem_rdata(imem_rdata),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_req(dmem_req), .dmem_resp_valid(dmem_resp_valid), .dmem_rdata(dmem_rdata),
        .commit_valid(commit_valid), .commit(commit)
    );

    function automatic int unsigned pick(int unsigned lo, int unsigned hi);
        return $urandom_range(hi, lo);
    endfunction

    // unused slots hold words with an unknown opcode
    function automatic logic [31:0] imem_fill(logic [31:0] addr);
        return {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'h00};
    endfunction

    function automatic logic [31:0] dmem_fill(int i);
        logic [31:0] addr;
        addr = i * 4;
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] lane_bits(logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural model, one instruction at ref_pc
    task automatic ref_exec(input logic [31:0] w);
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a, b, ii, si, bi, ji, wd, nxt, addr, val;
        logic        we;
        logic        taken;
        int          lane, nb;
        mem_req_t    st;
        op = w[6:0];
        rd = w[11:7];
        f3 = w[14:12];
        a = rregs[w[19:15]];
        b = rregs[w[24:20]];
        ii = {{20{w[31]}}, w[31:20]};
        si = {{20{w[31]}}, w[31:25], w[11:7]};
        bi = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        ji = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        nxt = ref_pc + 4;
        wd = '0;
        we = 1'b1;
        taken = 1'b0;
        addr = a + ((op == OP_STORE) ? si : ii);
        lane = int'(addr[1:0]);
        nb = 1 << f3[1:0];
        case (op)
            OP_LUI:   wd = {w[31:12], 12'h000};
            OP_AUIPC: wd = ref_pc + {w[31:12], 12'h000};
            OP_JAL: begin
                wd = ref_pc + 4;
                nxt = ref_pc + ji;
            end
            OP_JALR: begin
                wd = ref_pc + 4;
                nxt = addr & ~32'd1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                we = 1'b0;
                if (taken)
                    nxt = ref_pc + bi;
            end
            OP_LOAD: begin
                val = ref_dmem[addr[9:2]];
                for (int k = 0; k < nb; k++)
                    wd[8*k +: 8] = val[8*(lane+k) +: 8];
                if (!f3[2] && nb == 1)
                    wd = {{24{wd[7]}}, wd[7:0]};
                else if (!f3[2] && nb == 2)
                    wd = {{16{wd[15]}}, wd[15:0]};
            end
            OP_STORE: begin
                we = 1'b0;
                st = '0;
                st.addr = addr;
                st.write = 1'b1;
                for (int k = 0; k < nb; k++) begin
                    st.wmask[lane+k] = 1'b1;
                    st.wdata[8*(lane+k) +: 8] = b[8*k +: 8];
                    ref_dmem[addr[9:2]][8*(lane+k) +: 8] = b[8*k +: 8];
                end
                store_q.push_back(st);
                store_test.push_back(cur_test);
            end
            OP_IMM:  wd = ref_alu(f3, f3 == 3'd5 && w[30], a, ii);
            OP_REG:  wd = ref_alu(f3, w[30], a, b);
            default: we = 1'b0;
        endcase
        if (rd == 5'd0)
            we = 1'b0;
        if (we)
            rregs[rd] = wd;
        exp_q.push_back('{pc: ref_pc, rd: rd, wdata: wd, we: we});
        exp_test.push_back(cur_test);
        test_len[cur_test]++;
        ref_pc = nxt;
    endtask

    task automatic emit(input logic [31:0] w);
        imem[(ref_pc - RESET_PC) >> 2] = w;
        ref_exec(w);
    endtask

    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit({hi[19:0], 5'(rd), OP_LUI});
        emit(enc_i(v[11:0], rd, 0, rd, OP_IMM));
    endtask

    task automatic random_imm_op(input int rd, input int rs1);
        logic [11:0] imm;
        int          f3;
        f3 = pick(0, 7);
        imm = 12'($urandom);
        if (f3 == 1 || f3 == 5)
            imm[11:5] = (f3 == 5 && pick(0, 1) == 1) ? 7'h20 : 7'h00;
        emit(enc_i(imm, rs1, f3, rd, OP_IMM));
    endtask

    task automatic build_alu();
        for (int r = 1; r <= 8; r++)
            load_const(r, $urandom);
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, pick(1, 8), pick(1, 8), f, pick(9, 15), OP_REG));
            if (f == 0 || f == 5)
                emit(enc_r(7'h20, pick(1, 8), pick(1, 8), f, pick(9, 15), OP_REG));
        end
        for (int n = 0; n < 12; n++)
            random_imm_op(pick(9, 15), pick(1, 8));
        emit(enc_i(12'h123, 1, 0, 0, OP_IMM));  // writes to x0
        emit(enc_r(7'h00, 2, 1, 0, 0, OP_REG));
        emit(enc_r(7'h00, 0, 0, 0, 16, OP_REG));
        emit(enc_i(12'h7ff, 0, 6, 17, OP_IMM));
    endtask

    task automatic build_branch();
        int conds[6];
        conds = '{0, 1, 4, 5, 6, 7};
        foreach (conds[i]) begin
            load_const(1, $urandom);
            load_const(2, $urandom);
            emit(enc_b(13'd8, 2, 1, conds[i]));
            emit(enc_b(13'd12, 1, 1, conds[i]));
            emit(enc_b(13'd8, 1, 2, conds[i]));
        end
        emit(enc_j(21'(4 * pick(2, 4)), 5));
        emit(enc_j(21'd8, 0));
        emit({20'h00000, 5'd6, OP_AUIPC});
        emit(enc_i(12'(9 + 4 * pick(1, 3)), 6, 0, 7, OP_JALR));  // odd offset, bit 0 dropped
        emit(enc_r(7'h00, 7, 5, 0, 8, OP_REG));
    endtask

    task automatic build_mem();
        int base;
        for (int n = 0; n < 6; n++) begin
            load_const(10, $urandom);
            base = 4 * pick(0, DMEM_WORDS - 1);
            emit(enc_s(12'(base), 10, 0, 2));
            emit(enc_s(12'(base + pick(0, 3)), 10, 0, 0));
            emit(enc_s(12'(base + 2 * pick(0, 1)), 10, 0, 1));
            emit(enc_i(12'(base + pick(0, 3)), 0, 0, pick(11, 15), OP_LOAD));
            emit(enc_i(12'(base + pick(0, 3)), 0, 4, pick(11, 15), OP_LOAD));
            emit(enc_i(12'(base + 2 * pick(0, 1)), 0, 1, pick(11, 15), OP_LOAD));
            emit(enc_i(12'(base + 2 * pick(0, 1)), 0, 5, pick(11, 15), OP_LOAD));
            emit(enc_i(12'(base), 0, 2, pick(11, 15), OP_LOAD));
        end
    endtask

    task automatic build_mix();
        int f3;
        int kind;
        for (int n = 0; n < 40; n++) begin
            kind = pick(0, 5);
            f3 = pick(0, 7);
            case (kind)
                0: begin
                    emit(enc_r((f3 == 0 || f3 == 5) && pick(0, 1) == 1 ? 7'h20 : 7'h00,
                               pick(1, 15), pick(1, 15), f3, pick(1, 15), OP_REG));
                end
                1: random_imm_op(pick(1, 15), pick(1, 15));
                2: emit(enc_s(12'(4 * pick(0, 255)), pick(1, 15), 0, pick(0, 2)));
                3: emit(enc_i(12'(4 * pick(0, 255)), 0, pick(0, 2), pick(1, 15), OP_LOAD));
                4: emit(enc_b(13'd8, pick(1, 15), pick(1, 15), (f3 == 2 || f3 == 3) ? 0 : f3));
                default: load_const(pick(1, 15), $urandom);
            endcase
        end
    endtask

    task automatic report_fail(input int test, input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        errors[test]++;
    endtask

    // instruction memory, random ready and 1 to 4 cycle response
    logic       imem_pending = 1'b0;
    logic [1:0] imem_delay = '0;
    logic [31:0] imem_word = '0;
    always @(posedge clk) begin
        imem_req_ready <= (pick(0, 3) != 0);
        imem_resp_valid <= 1'b0;
        if (imem_pending) begin
            if (imem_delay == 0) begin
                imem_resp_valid <= 1'b1;
                imem_rdata <= imem_word;
                imem_pending <= 1'b0;
            end else begin
                imem_delay <= imem_delay - 1;
            end
        end else if (!reset && imem_req_valid && imem_req_ready) begin
            imem_pending <= 1'b1;
            imem_delay <= 2'(pick(0, 3));
            if (imem_addr - RESET_PC < IMEM_WORDS * 4)
                imem_word <= imem[(imem_addr - RESET_PC) >> 2];
            else
                imem_word <= imem_fill(imem_addr);
        end
    end

    // data memory, same timing, stores applied on acceptance
    logic       dmem_pending = 1'b0;
    logic [1:0] dmem_delay = '0;
    logic [31:0] dmem_word = '0;
    always @(posedge clk) begin
        dmem_req_ready <= (pick(0, 3) != 0);
        dmem_resp_valid <= 1'b0;
        if (dmem_pending) begin
            if (dmem_delay == 0) begin
                dmem_resp_valid <= 1'b1;
                dmem_rdata <= dmem_word;
                dmem_pending <= 1'b0;
            end else begin
                dmem_delay <= dmem_delay - 1;
            end
        end else if (!reset && dmem_req_valid && dmem_req_ready) begin
            dmem_pending <= 1'b1;
            dmem_delay <= 2'(pick(0, 3));
            dmem_word <= dmem[dmem_req.addr[9:2]];
            for (int k = 0; k < 4; k++)
                if (dmem_req.write && dmem_req.wmask[k])
                    dmem[dmem_req.addr[9:2]][8*k +: 8] = dmem_req.wdata[8*k +: 8];
        end
    end

    always @(posedge clk) begin : checks
        commit_t  exp;
        mem_req_t st;
        int       t;
        if (reset) begin
            // outputs are unknown until the first reset edge
            if (cycles > 0) begin
                assert (!commit_valid && !imem_req_valid && !dmem_req_valid)
                    else report_fail(0, "request or commit seen during reset");
            end
        end else begin
            if (commit_valid && !all_done) begin
                inst_busy = 1'b0;
                data_busy = 1'b0;
                exp = exp_q.pop_front();
                t = exp_test.pop_front();
                assert (commit.pc == exp.pc && commit.we == exp.we)
                    else report_fail(t, $sformatf("commit pc %h we %b, expected pc %h we %b",
                                                  commit.pc, commit.we, exp.pc, exp.we));
                if (exp.we) begin
                    assert (commit.rd == exp.rd && commit.wdata == exp.wdata)
                        else report_fail(t, $sformatf("pc %h wrote x%0d=%h, expected x%0d=%h",
                                         exp.pc, commit.rd, commit.wdata, exp.rd, exp.wdata));
                end
                seen[t]++;
                if (t < NUM_TESTS - 1 && seen[t] == test_len[t])
                    $display("test %0d %s: %0d commits, %0d failures", t, names[t], seen[t],
                             errors[t]);
                if (exp_q.size() == 0)
                    all_done = 1'b1;
            end
            if (imem_req_valid && !first_req_seen) begin
                first_req_seen = 1'b1;
                assert (imem_addr == RESET_PC)
                    else report_fail(0, $sformatf("first fetch at %h", imem_addr));
                $display("test 0 %s: %0d failures", names[0], errors[0]);
            end
            if (imem_req_valid && imem_req_ready) begin
                assert (!inst_busy)
                    else begin
                        $display("second fetch at %h before the previous instruction committed",
                                 imem_addr);
                        errors[4]++;
                    end
                inst_busy = 1'b1;
            end
            if (dmem_req_valid && dmem_req_ready) begin
                assert (!data_busy)
                    else begin
                        $display("second data request at %h in one instruction",
                                 dmem_req.addr);
                        errors[4]++;
                    end
                data_busy = 1'b1;
                if (dmem_req.write) begin
                    st = store_q.pop_front();
                    t = store_test.pop_front();
                    assert (dmem_req.addr == st.addr && dmem_req.wmask == st.wmask
                            && (dmem_req.wdata & lane_bits(st.wmask)) == st.wdata)
                        else report_fail(t, $sformatf("store %h mask %b data %h, expected %h %b %h",
                                         dmem_req.addr, dmem_req.wmask, dmem_req.wdata,
                                         st.addr, st.wmask, st.wdata));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles with %0d commits still missing", cycles,
                     exp_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        void'($urandom(SEED));
        ref_pc = RESET_PC;
        for (int i = 0; i < 32; i++)
            rregs[i] = '0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = imem_fill(RESET_PC + 32'(i * 4));
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = dmem_fill(i);
            ref_dmem[i] = dmem_fill(i);
        end
        cur_test = 1;
        build_alu();
        cur_test = 2;
        build_branch();
        cur_test = 3;
        build_mem();
        cur_test = 4;
        build_mix();
        limit = exp_q.size() * 16 + RESET_CYCLES;
        wait (all_done);
        repeat (4) @(posedge clk);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] == ref_dmem[i])
                else report_fail(4, $sformatf("data word %0d is %h, expected %h", i, dmem[i],
                                              ref_dmem[i]));
        end
        $display("test 4 %s: %0d commits, %0d failures", names[4], seen[4], errors[4]);
        total = 0;
        foreach (errors[i])
            total += errors[i];
        $display("%0d tests, %0d commits, %0d failures", NUM_TESTS, seen.sum(), total);
        if (total == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tb.f
common/npc_pkg.sv
exu/alu.sv
exu/exu.sv
rtl/ifu.sv
rtl/idu.sv
rtl/lsu.sv
rtl/gpr.sv
rtl/npc_core.sv
tests/tb_clock.sv
tests/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= npc_core
SEED      ?= 1
BUILD     ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing -Wno-fatal

RTL_SRCS := $(shell grep -v '^tests/' $(FILELIST))
ALL_SRCS := $(shell cat $(FILELIST))

.PHONY: run lint clean

run: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

$(BUILD)/V$(TOP): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD)
